// ==== rtl/frog_pkg.sv ====
// Frog crossing shared definitions
package frog_pkg;

	// ============================================================
	// Matrix and game types
	// ============================================================
	typedef logic [7:0]  row_t;
	typedef logic [2:0]  row_idx_t;
	typedef logic [1:0]  level_t;
	// Row 0 sits in the lowest byte
	typedef logic [63:0] frame_t;

	typedef enum logic [1:0] {
		GAME_IDLE,
		GAME_PLAY,
		GAME_OVER
	} game_state_t;

	// ============================================================
	// Geometry and timing
	// ============================================================
	localparam int MATRIX_ROWS = 8;

	// Lane scroll period, short for simulation
	localparam logic [31:0] TICK_CYCLES = 32'd256;

	localparam int LEVEL_COUNT = 4;

	// Lane patterns, row 7 down to row 0 in each word
	// Row 0 stays clear so the frog never starts on a lit cell
	localparam frame_t [LEVEL_COUNT-1:0] LEVEL_LANES = {
		64'h9B71_0C64_05CC_0200,
		64'h59B2_8165_00CC_2000,
		64'h9944_0082_10E6_0000,
		64'hDB00_8824_00CC_0000
	};

	// Frog column at start, one-hot
	localparam row_t FROG_START_COL = 8'h10;

	// ============================================================
	// MAX7219 serial framing
	// ============================================================
	localparam int MAX_WORD_BITS = 16;

	// Chip select high time between words
	localparam int MAX_GAP_CYCLES = 2;

endpackage

// ==== rtl/button_sync.sv ====
// Button synchronizer and press detect
`timescale 1ns/1ps

module button_sync (
	input  logic clock_50,
	input  logic arst_n,
	input  logic start_btn_n,
	input  logic up_btn_n,
	input  logic down_btn_n,
	input  logic left_btn_n,
	input  logic right_btn_n,
	output logic start_pulse,
	output logic up_pulse,
	output logic down_pulse,
	output logic left_pulse,
	output logic right_pulse
);

	// Order: start, up, down, left, right
	logic [4:0] btn;
	logic [4:0] sync_a;
	logic [4:0] sync_b;
	logic [4:0] sync_c;
	logic [4:0] pulse;

	// Buttons pull low when pressed
	assign btn = ~{start_btn_n, up_btn_n, down_btn_n, left_btn_n, right_btn_n};

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			sync_a <= '0;
			sync_b <= '0;
			sync_c <= '0;
			pulse  <= '0;
		end else begin
			sync_a <= btn;
			sync_b <= sync_a;
			sync_c <= sync_b;
			// Rising edge of the synchronized level
			pulse  <= sync_b & ~sync_c;
		end
	end

	assign {start_pulse, up_pulse, down_pulse, left_pulse, right_pulse} = pulse;

endmodule

// ==== rtl/frog_tracker.sv ====
// Frog position register
`timescale 1ns/1ps

module frog_tracker
	import frog_pkg::*;
(
	input  logic     clock_50,
	input  logic     arst_n,
	input  logic     frog_reset,
	input  logic     move_en,
	input  logic     up_pulse,
	input  logic     down_pulse,
	input  logic     left_pulse,
	input  logic     right_pulse,
	output row_idx_t frog_row,
	output row_t     frog_col
);

	// Row counts up toward the far side, column is a one-hot mask
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			frog_row <= '0;
			frog_col <= FROG_START_COL;
		end else if (frog_reset) begin
			frog_row <= '0;
			frog_col <= FROG_START_COL;
		end else if (move_en) begin
			if (up_pulse) begin
				if (frog_row != 3'd7)
					frog_row <= frog_row + 3'd1;
			end else if (down_pulse) begin
				if (frog_row != 3'd0)
					frog_row <= frog_row - 3'd1;
			end else if (left_pulse) begin
				// Left is toward bit 7
				if (!frog_col[7])
					frog_col <= frog_col << 1;
			end else if (right_pulse) begin
				if (!frog_col[0])
					frog_col <= frog_col >> 1;
			end
		end
	end

	// Exactly one lit column at all times
	frog_col_onehot: assert property (@(posedge clock_50) disable iff (!arst_n)
		$onehot(frog_col));

endmodule

// ==== rtl/lane_scroller.sv ====
// Scrolling lane background
`timescale 1ns/1ps

module lane_scroller
	import frog_pkg::*;
(
	input  logic   clock_50,
	input  logic   arst_n,
	input  logic   lane_load,
	input  level_t level,
	input  logic   scroll_en,
	output frame_t lanes
);

	logic [31:0] prescale;
	logic        tick;

	// ============================================================
	// Speed prescaler
	// ============================================================
	assign tick = scroll_en && (prescale == TICK_CYCLES - 32'd1);

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			prescale <= '0;
		end else if (lane_load) begin
			prescale <= '0;
		end else if (scroll_en) begin
			if (tick)
				prescale <= '0;
			else
				prescale <= prescale + 32'd1;
		end
	end

	// ============================================================
	// Lane rows
	// ============================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			lanes <= LEVEL_LANES[0];
		end else if (lane_load) begin
			lanes <= LEVEL_LANES[level];
		end else if (tick) begin
			// Every row drops one index, row 0 comes back in at row 7
			lanes <= {lanes[7:0], lanes[63:8]};
		end
	end

endmodule

// ==== rtl/game_core.sv ====
// Game control and frame composition
`timescale 1ns/1ps

module game_core
	import frog_pkg::*;
(
	input  logic   clock_50,
	input  logic   arst_n,
	input  logic   start_pulse,
	input  logic   up_pulse,
	input  logic   down_pulse,
	input  logic   left_pulse,
	input  logic   right_pulse,
	output frame_t frame,
	output level_t level,
	output logic   game_over
);

	game_state_t state;
	game_state_t state_next;
	row_idx_t    frog_row;
	row_t        frog_col;
	frame_t      lanes;
	frame_t      frog_cell;
	level_t      level_next;
	logic        move_en;
	logic        scroll_en;
	logic        frog_reset;
	logic        lane_load;
	logic        collision;
	logic        advance;
	logic        restart;

	frog_tracker u_frog_tracker (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.frog_reset  (frog_reset),
		.move_en     (move_en),
		.up_pulse    (up_pulse),
		.down_pulse  (down_pulse),
		.left_pulse  (left_pulse),
		.right_pulse (right_pulse),
		.frog_row    (frog_row),
		.frog_col    (frog_col)
	);

	lane_scroller u_lane_scroller (
		.clock_50  (clock_50),
		.arst_n    (arst_n),
		.lane_load (lane_load),
		.level     (level_next),
		.scroll_en (scroll_en),
		.lanes     (lanes)
	);

	// ============================================================
	// Collision and level control
	// ============================================================
	assign frog_cell = frame_t'(frog_col) << {frog_row, 3'b000};
	assign collision = |(lanes[{frog_row, 3'b000} +: 8] & frog_col);

	// Top row reached safely
	assign advance = (state == GAME_PLAY) && !collision && (frog_row == 3'd7);
	assign restart = (state == GAME_OVER) && start_pulse;

	assign level_next = advance ? level + 2'd1 : level;
	assign frog_reset = advance || restart;
	assign lane_load  = advance || restart;
	assign move_en    = (state == GAME_PLAY);
	assign scroll_en  = (state == GAME_PLAY);
	assign game_over  = (state == GAME_OVER);

	always_comb begin
		state_next = state;
		case (state)
			GAME_IDLE: if (start_pulse) state_next = GAME_PLAY;
			GAME_PLAY: if (collision) state_next = GAME_OVER;
			GAME_OVER: if (start_pulse) state_next = GAME_PLAY;
			default:   state_next = GAME_IDLE;
		endcase
	end

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= GAME_IDLE;
			level <= '0;
			frame <= LEVEL_LANES[0] | frame_t'(FROG_START_COL);
		end else begin
			state <= state_next;
			level <= level_next;
			// The crash picture stays up during game over
			if (state != GAME_OVER)
				frame <= lanes | frog_cell;
		end
	end

	level_change_in_play: assert property (@(posedge clock_50) disable iff (!arst_n)
		$changed(level) |-> $past(state) == GAME_PLAY);

endmodule

// ==== rtl/frame_latch.sv ====
// Frame snapshot for the serializer
`timescale 1ns/1ps

module frame_latch
	import frog_pkg::*;
(
	input  logic                   clock_50,
	input  logic                   arst_n,
	input  frame_t                 frame,
	input  logic                   frame_ready,
	output row_t [MATRIX_ROWS-1:0] cols,
	output logic                   frame_valid
);

	row_t [MATRIX_ROWS-1:0] cols_next;

	// Column c carries row 0 in its MSB and row 7 in its LSB
	always_comb begin
		for (int c = 0; c < MATRIX_ROWS; c++) begin
			for (int r = 0; r < MATRIX_ROWS; r++) begin
				cols_next[c][MATRIX_ROWS-1-r] = frame[r*MATRIX_ROWS + c];
			end
		end
	end

	// ============================================================
	// Valid/ready hold
	// ============================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			frame_valid <= 1'b0;
		end else if (frame_valid && frame_ready) begin
			frame_valid <= 1'b0;
		end else if (!frame_valid) begin
			frame_valid <= 1'b1;
		end
	end

	// Refill one cycle after each hand-off
	always_ff @(posedge clock_50) begin
		if (!frame_valid)
			cols <= cols_next;
	end

endmodule

// ==== rtl/max7219_tx.sv ====
// MAX7219 frame serializer
`timescale 1ns/1ps

module max7219_tx
	import frog_pkg::*;
(
	input  logic                   clock_50,
	input  logic                   arst_n,
	input  row_t [MATRIX_ROWS-1:0] cols,
	input  logic                   frame_valid,
	output logic                   frame_ready,
	output logic                   max_din,
	output logic                   max_ncs,
	output logic                   max_clk
);

	localparam int BIT_W = $clog2(MAX_WORD_BITS);
	localparam int GAP_W = $clog2(MAX_GAP_CYCLES + 1);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(MAX_WORD_BITS - 1);
	localparam logic [GAP_W-1:0] LAST_GAP = GAP_W'(MAX_GAP_CYCLES - 1);

	typedef enum logic [1:0] {TX_IDLE, TX_SHIFT, TX_GAP} tx_state_t;

	tx_state_t              state;
	row_t [MATRIX_ROWS-1:0] col_buf;
	row_idx_t               word_cnt;
	logic [BIT_W-1:0]       bit_cnt;
	logic                   phase;
	logic [GAP_W-1:0]       gap_cnt;
	logic [3:0]             addr;
	logic [MAX_WORD_BITS-1:0] word_bits;

	// Digit registers 1..8, word k shows column 7-k
	assign addr      = {1'b0, word_cnt} + 4'd1;
	assign word_bits = {4'd0, addr, col_buf[3'd7 - word_cnt]};

	assign frame_ready = (state == TX_IDLE);
	assign max_ncs     = (state != TX_SHIFT);
	// Low half then high half of each bit period
	assign max_clk     = (state == TX_SHIFT) && phase;
	assign max_din     = (state == TX_SHIFT) && word_bits[LAST_BIT - bit_cnt];

	always_ff @(posedge clock_50) begin
		if (frame_valid && frame_ready)
			col_buf <= cols;
	end

	// ============================================================
	// Word, bit and gap sequencing
	// ============================================================
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state    <= TX_IDLE;
			word_cnt <= '0;
			bit_cnt  <= '0;
			phase    <= 1'b0;
			gap_cnt  <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (frame_valid) begin
						state    <= TX_SHIFT;
						word_cnt <= '0;
						bit_cnt  <= '0;
						phase    <= 1'b0;
					end
				end
				TX_SHIFT: begin
					phase <= ~phase;
					if (phase) begin
						// Wraps back to 0 after the last bit
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == LAST_BIT) begin
							state   <= TX_GAP;
							gap_cnt <= '0;
						end
					end
				end
				TX_GAP: begin
					gap_cnt <= gap_cnt + 1'b1;
					if (gap_cnt == LAST_GAP) begin
						if (word_cnt == 3'd7) begin
							state <= TX_IDLE;
						end else begin
							word_cnt <= word_cnt + 3'd1;
							state    <= TX_SHIFT;
						end
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Ready comes back only once all eight words are out
	ready_after_last_word: assert property (@(posedge clock_50) disable iff (!arst_n)
		$rose(frame_ready) |-> word_cnt == 3'd7);

	// Chip select stays high for the full gap before each word
	gap_before_word: assert property (@(posedge clock_50) disable iff (!arst_n)
		$fell(max_ncs) |-> $past(max_ncs, MAX_GAP_CYCLES));

endmodule

// ==== rtl/frog_top.sv ====
// Frog crossing game top level
`timescale 1ns/1ps

module frog_top
	import frog_pkg::*;
(
	input  logic   clock_50,
	input  logic   arst_n,
	input  logic   start_btn_n,
	input  logic   up_btn_n,
	input  logic   down_btn_n,
	input  logic   left_btn_n,
	input  logic   right_btn_n,
	output logic   max_din,
	output logic   max_ncs,
	output logic   max_clk,
	output level_t level,
	output logic   game_over
);

	logic                   start_pulse;
	logic                   up_pulse;
	logic                   down_pulse;
	logic                   left_pulse;
	logic                   right_pulse;
	frame_t                 frame;
	row_t [MATRIX_ROWS-1:0] cols;
	logic                   frame_valid;
	logic                   frame_ready;

	// ============================================================
	// Buttons to game
	// ============================================================
	button_sync u_button_sync (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.start_btn_n (start_btn_n),
		.up_btn_n    (up_btn_n),
		.down_btn_n  (down_btn_n),
		.left_btn_n  (left_btn_n),
		.right_btn_n (right_btn_n),
		.start_pulse (start_pulse),
		.up_pulse    (up_pulse),
		.down_pulse  (down_pulse),
		.left_pulse  (left_pulse),
		.right_pulse (right_pulse)
	);

	game_core u_game_core (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.start_pulse (start_pulse),
		.up_pulse    (up_pulse),
		.down_pulse  (down_pulse),
		.left_pulse  (left_pulse),
		.right_pulse (right_pulse),
		.frame       (frame),
		.level       (level),
		.game_over   (game_over)
	);

	// ============================================================
	// Frame to LED driver
	// ============================================================
	frame_latch u_frame_latch (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.frame       (frame),
		.frame_ready (frame_ready),
		.cols        (cols),
		.frame_valid (frame_valid)
	);

	max7219_tx u_max7219_tx (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.cols        (cols),
		.frame_valid (frame_valid),
		.frame_ready (frame_ready),
		.max_din     (max_din),
		.max_ncs     (max_ncs),
		.max_clk     (max_clk)
	);

endmodule

// ==== verif/tb_clock.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock (
	output logic clock_50,
	output logic arst_n
);

	// 4 ns period
	initial begin
		clock_50 = 1'b0;
		forever #2 clock_50 = ~clock_50;
	end

	// Reset held for 16 cycles, released on a falling edge
	initial begin
		arst_n = 1'b0;
		repeat (16) @(posedge clock_50);
		@(negedge clock_50);
		arst_n = 1'b1;
	end

endmodule

// ==== verif/tb_frog_top.sv ====
// Frog crossing game testbench
`timescale 1ns/1ps

module tb_frog_top
	import frog_pkg::*;
();

	localparam int PRESS_COUNT = 120;
	// Cycles allowed per LED frame before a timeout
	localparam int FRAME_LIMIT = 400;

	logic        clock_50;
	logic        arst_n;
	logic        start_btn_n;
	logic        up_btn_n;
	logic        down_btn_n;
	logic        left_btn_n;
	logic        right_btn_n;
	logic        max_din;
	logic        max_ncs;
	logic        max_clk;
	level_t      level;
	logic        game_over;

	// Game model
	game_state_t model_state;
	level_t      model_level;
	int          frog_row;
	int          prev_row;
	row_t        frog_col;
	row_t        prev_col;
	logic        top_reached;
	frame_t      frozen;
	logic        frozen_valid;

	// MAX7219 word decoder
	logic [15:0] word_sr;
	int          bit_count;
	int          exp_addr;
	frame_t      decoded;
	logic        clk_prev;
	logic        ncs_prev;
	int          frame_count;
	int          skip_frames;

	int          errors;
	int          checks;
	logic [31:0] rng_state;

	tb_clock u_tb_clock (
		.clock_50 (clock_50),
		.arst_n   (arst_n)
	);

	frog_top uut (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.start_btn_n (start_btn_n),
		.up_btn_n    (up_btn_n),
		.down_btn_n  (down_btn_n),
		.left_btn_n  (left_btn_n),
		.right_btn_n (right_btn_n),
		.max_din     (max_din),
		.max_ncs     (max_ncs),
		.max_clk     (max_clk),
		.level       (level),
		.game_over   (game_over)
	);

	// ============================================================
	// Helpers
	// ============================================================
	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	function automatic frame_t frog_cell(input int row, input row_t col);
		frame_t c;
		c = '0;
		c[row*8 +: 8] = col;
		return c;
	endfunction

	// Rows move down one index per step, row 0 wraps to row 7
	function automatic frame_t rotate_lanes(input frame_t base, input int steps);
		frame_t r;
		for (int row = 0; row < MATRIX_ROWS; row++)
			r[row*8 +: 8] = base[((row + steps) % MATRIX_ROWS)*8 +: 8];
		return r;
	endfunction

	function automatic logic cell_lit(input frame_t f, input int row, input row_t col);
		return |(f[row*8 +: 8] & col);
	endfunction

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	task automatic set_button(input int btn, input logic value);
		case (btn)
			0: start_btn_n = value;
			1: up_btn_n = value;
			2: down_btn_n = value;
			3: left_btn_n = value;
			default: right_btn_n = value;
		endcase
	endtask

	task automatic reset_frog();
		frog_row = 0;
		frog_col = FROG_START_COL;
		prev_row = 0;
		prev_col = FROG_START_COL;
	endtask

	task automatic note_game_over();
		if (model_state == GAME_PLAY && game_over) begin
			model_state  = GAME_OVER;
			frozen_valid = 1'b0;
			skip_frames  = 2;
		end
	endtask

	// ============================================================
	// Frame checks against the model
	// ============================================================
	task automatic check_frame(input frame_t f);
		frame_t rot;
		logic   found;
		checks++;
		if (level != model_level) begin
			errors++;
			$display("Error: level expected %h got %h", model_level, level);
		end
		found = 1'b0;
		case (model_state)
			GAME_IDLE: begin
				rot = LEVEL_LANES[0] | frog_cell(0, FROG_START_COL);
				if (f != rot) begin
					errors++;
					$display("Error: decoded frame expected %h got %h", rot, f);
				end
				if (game_over) begin
					errors++;
					$display("Error: game_over expected %h got %h", 1'b0, game_over);
				end
			end
			GAME_PLAY: begin
				for (int k = 0; k < MATRIX_ROWS; k++) begin
					rot = rotate_lanes(LEVEL_LANES[model_level], k);
					if (!cell_lit(rot, frog_row, frog_col) &&
							f == (rot | frog_cell(frog_row, frog_col)))
						found = 1'b1;
				end
				if (!found) begin
					errors++;
					$display("Error: decoded frame %h fits no lanes of level %h, frog row %h mask %h",
						f, model_level, frog_row, frog_col);
				end
			end
			default: begin
				if (!game_over) begin
					errors++;
					$display("Error: game_over expected %h got %h", 1'b1, game_over);
				end
				if (frozen_valid) begin
					if (f != frozen) begin
						errors++;
						$display("Error: decoded frame expected %h got %h", frozen, f);
					end
				end else begin
					// Crash picture, frog on a lit lane cell
					for (int k = 0; k < MATRIX_ROWS; k++) begin
						rot = rotate_lanes(LEVEL_LANES[model_level], k);
						if (f == rot && (cell_lit(rot, frog_row, frog_col) ||
								cell_lit(rot, prev_row, prev_col)))
							found = 1'b1;
					end
					if (!found) begin
						errors++;
						$display("Error: decoded frame %h shows no crash at row %h mask %h",
							f, frog_row, frog_col);
					end
					frozen       = f;
					frozen_valid = 1'b1;
				end
			end
		endcase
	endtask

	task automatic end_word();
		checks++;
		if (bit_count != MAX_WORD_BITS) begin
			errors++;
			$display("Error: max_clk rises per word expected %h got %h", MAX_WORD_BITS, bit_count);
		end
		if (word_sr[15:8] != 8'(exp_addr)) begin
			errors++;
			$display("Error: max word address expected %h got %h", 8'(exp_addr), word_sr[15:8]);
		end else begin
			// Data MSB is row 0, word k carries column 7-k
			for (int r = 0; r < MATRIX_ROWS; r++)
				decoded[r*8 + 8 - exp_addr] = word_sr[7-r];
		end
		if (exp_addr == MATRIX_ROWS) begin
			frame_count++;
			if (skip_frames > 0)
				skip_frames--;
			else
				check_frame(decoded);
			exp_addr = 1;
		end else begin
			exp_addr++;
		end
		bit_count = 0;
	endtask

	// Pin sampling at mid cycle
	always @(negedge clock_50) begin
		if (arst_n) begin
			note_game_over();
			if (!max_ncs && max_clk && !clk_prev) begin
				word_sr = {word_sr[14:0], max_din};
				bit_count++;
			end
			if (max_ncs && !ncs_prev)
				end_word();
		end
		clk_prev = max_clk;
		ncs_prev = max_ncs;
	end

	// ============================================================
	// Stimulus
	// ============================================================
	task automatic wait_frames(input int count);
		int target;
		int cycles;
		target = frame_count + count;
		cycles = 0;
		while (frame_count < target && cycles < count * FRAME_LIMIT) begin
			@(negedge clock_50);
			cycles++;
		end
		if (frame_count < target) begin
			errors++;
			$display("Timeout: no complete LED frame within %0d cycles", cycles);
			finish_run();
		end
	endtask

	// Move seen by the frog on the fourth rising edge after the press
	task automatic apply_move(input int btn);
		note_game_over();
		if (btn != 0 && model_state == GAME_PLAY) begin
			prev_row = frog_row;
			prev_col = frog_col;
			case (btn)
				1: if (frog_row < 7) frog_row++;
				2: if (frog_row > 0) frog_row--;
				3: if (!frog_col[7]) frog_col = frog_col << 1;
				default: if (!frog_col[0]) frog_col = frog_col >> 1;
			endcase
			top_reached = (frog_row == 7);
			skip_frames = 2;
		end
	endtask

	task automatic apply_start(input int btn);
		if (btn == 0 && model_state != GAME_PLAY) begin
			checks++;
			if (game_over) begin
				errors++;
				$display("Error: game_over expected %h got %h", 1'b0, game_over);
			end
			if (level != model_level) begin
				errors++;
				$display("Error: level expected %h got %h", model_level, level);
			end
			model_state = GAME_PLAY;
			reset_frog();
			skip_frames = 2;
		end
	endtask

	task automatic check_advance();
		if (top_reached) begin
			top_reached = 1'b0;
			note_game_over();
			if (model_state == GAME_PLAY) begin
				checks++;
				if (level != level_t'(model_level + 2'd1)) begin
					errors++;
					$display("Error: level expected %h got %h", level_t'(model_level + 2'd1), level);
				end
				model_level = model_level + 2'd1;
				reset_frog();
				skip_frames = 2;
			end
		end
	endtask

	task automatic press_button(input int btn);
		@(negedge clock_50);
		set_button(btn, 1'b0);
		repeat (3) @(negedge clock_50);
		apply_move(btn);
		@(negedge clock_50);
		set_button(btn, 1'b1);
		apply_start(btn);
		@(negedge clock_50);
		check_advance();
	endtask

	initial begin
		int          cycles;
		int          btn;
		logic [31:0] r;
		start_btn_n  = 1'b1;
		up_btn_n     = 1'b1;
		down_btn_n   = 1'b1;
		left_btn_n   = 1'b1;
		right_btn_n  = 1'b1;
		rng_state    = 32'd60;
		model_state  = GAME_IDLE;
		model_level  = '0;
		reset_frog();
		top_reached  = 1'b0;
		frozen       = '0;
		frozen_valid = 1'b0;
		word_sr      = '0;
		bit_count    = 0;
		exp_addr     = 1;
		decoded      = '0;
		clk_prev     = 1'b0;
		ncs_prev     = 1'b1;
		frame_count  = 0;
		skip_frames  = 0;
		errors       = 0;
		checks       = 0;

		cycles = 0;
		while (!arst_n && cycles < 64) begin
			@(negedge clock_50);
			cycles++;
		end
		if (!arst_n) begin
			errors++;
			$display("Reset was never released");
			finish_run();
		end

		// Idle frames before any press
		wait_frames(3);

		for (int i = 0; i < PRESS_COUNT; i++) begin
			r = next_random();
			case (r[18:16])
				3'd0, 3'd7: btn = 0;
				3'd1, 3'd2, 3'd3: btn = 1;
				3'd4: btn = 2;
				3'd5: btn = 3;
				default: btn = 4;
			endcase
			press_button(btn);
			wait_frames(3);
			repeat (r[27:20]) @(negedge clock_50);
		end

		finish_run();
	end

endmodule

// ==== build.f ====
rtl/frog_pkg.sv
rtl/button_sync.sv
rtl/frog_tracker.sv
rtl/lane_scroller.sv
rtl/game_core.sv
rtl/frame_latch.sv
rtl/max7219_tx.sv
rtl/frog_top.sv
verif/tb_clock.sv
verif/tb_frog_top.sv

// ==== Makefile ====
TOP = tb_frog_top

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
